// File: vlog.f
+incdir+hdl
hdl/dumpScalePkg.sv
hdl/creditFifo.sv
hdl/sampleIngress.sv
hdl/dumpAccumulator.sv
hdl/accumScaler.sv
hdl/resultEgress.sv
hdl/dumpScaleTop.sv
test/dumpScaleTb.sv

// File: run.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and checks the log for the pass line.

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --assert --top-module dumpScaleTb -f vlog.f > build.log 2>&1 \
    && ./obj_dir/VdumpScaleTb > sim.log 2>&1 \
    || { cat build.log; echo "build or run did not complete"; }

[ -f sim.log ] && cat sim.log
grep -qx "TEST PASSED" sim.log 2>/dev/null && echo "run.sh: simulation ok" \
    || { echo "run.sh: simulation failed"; exit 1; }

// File: test/dumpScaleTb.sv
// ====================
// dumpScaleTb
// Testbench for the dumped integrator. Credit-driven stimulus on both
// ends, a model of the gain/accumulate/shift/clamp rule, and
// concurrent assertions that do the checking.
// ====================
`default_nettype none

`include "dumpScale_macros.svh"

module dumpScaleTb;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int plannedSamples = 240;
    localparam int openCap = 1000000;

    logic                 clk;
    logic                 rstN;
    logic                 inValid;
    dumpScalePkg::sampleT inSample;
    logic                 inLast;
    logic                 inCredit;
    dumpScalePkg::sampleT gain;
    dumpScalePkg::shiftT  shift;
    logic                 outValid;
    dumpScalePkg::resultT outResult;
    logic                 outCredit;

    int          samplesPushed = 0;
    int          creditsReturned = 0;
    int          grantsGiven = 0;
    int          resultsSeen = 0;
    int          sinceReset = 0;
    int          grantCap = openCap;
    int          expCount = 0;
    int          errors = 0;
    int          gainVal = 0;
    int          shiftVal = 0;
    bit          gapsOn = 1'b1;
    logic [31:0] seqState;
    logic [31:0] stimState;
    logic [31:0] grantState;
    string       testName = "reset";
    int          expArr [plannedSamples];
    string       expName [plannedSamples];
    int          dumpBuf [$];
    int          sampleQ [$];
    logic        lastQ [$];

    dumpScaleTop dumpScaleTop_inst (
        .clk       (clk),
        .rstN      (rstN),
        .inValid   (inValid),
        .inSample  (inSample),
        .inLast    (inLast),
        .inCredit  (inCredit),
        .gain      (gain),
        .shift     (shift),
        .outValid  (outValid),
        .outResult (outResult),
        .outCredit (outCredit)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    // the dumped sum wraps at 48 bits, then floor-shifts and clamps symmetrically.
    function automatic int expectedResult(input longint rawSum, input int sh);
        logic signed [`ACC_W-1:0] wrapped;
        longint                   value;
        wrapped = rawSum[`ACC_W-1:0];
        value = wrapped;
        value = value >>> ((sh > 30) ? 30 : sh);
        if (value > `SAT_MAX) begin
            return `SAT_MAX;
        end
        if (value < -(`SAT_MAX) - 1) begin
            return -(`SAT_MAX);
        end
        return int'(value);
    endfunction

    task automatic closeDump();
        longint sum;
        int     n;
        sum = 0;
        n = dumpBuf.size();
        for (int i = 0; i < n; i++) begin
            sum = sum + longint'(dumpBuf[i]) * longint'(gainVal);
            sampleQ.push_back(dumpBuf[i]);
            lastQ.push_back(i == n - 1);
        end
        dumpBuf.delete();
        expArr[expCount] = expectedResult(sum, shiftVal);
        expName[expCount] = testName;
        expCount++;
    endtask

    task automatic randomDump(input int lim, input int maxLen);
        int len;
        seqState = xorshift32(seqState);
        len = 1 + int'(seqState % 32'(maxLen));
        for (int i = 0; i < len; i++) begin
            seqState = xorshift32(seqState);
            dumpBuf.push_back(int'(seqState % 32'(2 * lim + 1)) - lim);
        end
        closeDump();
    endtask

    task automatic configure(input int g, input int sh);
        @(posedge clk);
        gain <= dumpScalePkg::sampleT'(g);
        shift <= dumpScalePkg::shiftT'(sh);
        gainVal = g;
        shiftVal = sh;
    endtask

    // gain and shift only change once nothing is in flight.
    task automatic drain();
        while (resultsSeen != expCount || sampleQ.size() != 0 || inValid) begin
            @(posedge clk);
        end
        repeat (4) @(posedge clk);
    endtask

    always @(posedge clk) begin : upstreamDriver
        int pushedNow;
        int returnedNow;
        pushedNow = samplesPushed + (inValid ? 1 : 0);
        returnedNow = creditsReturned + (inCredit ? 1 : 0);
        stimState = xorshift32(stimState);
        if (rstN) begin
            samplesPushed <= pushedNow;
            creditsReturned <= returnedNow;
            sinceReset <= sinceReset + 1;
            // a credit is held whenever fewer than IN_DEPTH entries are unreturned.
            if (sampleQ.size() > 0 && pushedNow - returnedNow < `IN_DEPTH
                && (!gapsOn || stimState[2:0] != 3'd0)) begin
                inValid <= 1'b1;
                inSample <= dumpScalePkg::sampleT'(sampleQ.pop_front());
                inLast <= lastQ.pop_front();
            end else begin
                inValid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin : downstreamDriver
        int grantedNow;
        int seenNow;
        grantedNow = grantsGiven + (outCredit ? 1 : 0);
        seenNow = resultsSeen + (outValid ? 1 : 0);
        grantState = xorshift32(grantState);
        if (rstN) begin
            grantsGiven <= grantedNow;
            resultsSeen <= seenNow;
            outCredit <= (grantedNow < grantCap) && (grantedNow - seenNow < 2)
                         && (grantState[1:0] != 2'd0);
        end
    end

    // checks run on the falling edge, where every DUT output is settled.
    resetQuiet: assert property (@(negedge clk)
        (!rstN || sinceReset < 3) |-> (!outValid && !inCredit))
        else begin
            errors++;
            $display("outValid or inCredit high during or right after reset");
        end

    creditsBounded: assert property (@(negedge clk) disable iff (!rstN)
        creditsReturned <= samplesPushed && (inCredit -> creditsReturned < samplesPushed))
        else begin
            errors++;
            $display("more input credits returned than samples pushed");
        end

    upstreamLegal: assert property (@(negedge clk) disable iff (!rstN)
        inValid |-> (samplesPushed - creditsReturned < `IN_DEPTH))
        else begin
            errors++;
            $display("upstream pushed a sample without holding a credit");
        end

    grantRespected: assert property (@(negedge clk) disable iff (!rstN)
        outValid |-> (grantsGiven > resultsSeen))
        else begin
            errors++;
            $display("result sent beyond the %0d downstream credits granted", grantsGiven);
        end

    resultExpected: assert property (@(negedge clk) disable iff (!rstN)
        outValid |-> (resultsSeen < expCount))
        else begin
            errors++;
            $display("unexpected extra result %0d", outResult);
        end

    resultValue: assert property (@(negedge clk) disable iff (!rstN)
        (outValid && resultsSeen < expCount) |-> (int'(outResult) == expArr[resultsSeen]))
        else begin
            errors++;
            $display("ERR %s expected %0d actual %0d", expName[resultsSeen],
                     expArr[resultsSeen], outResult);
        end

    initial begin : watchdog
        repeat (plannedSamples * 200) @(posedge clk);
        $display("timeout after %0d cycles, %0d of %0d results, %0d errors",
                 plannedSamples * 200, resultsSeen, expCount, errors);
        $display("TEST FAILED");
        $finish;
    end

    initial begin : mainSequence
        clk = 1'b0;
        rstN = 1'b0;
        inValid = 1'b0;
        inSample = '0;
        inLast = 1'b0;
        gain = '0;
        shift = '0;
        outCredit = 1'b0;
        seqState = 32'd86;
        stimState = xorshift32(32'd86);
        grantState = xorshift32(stimState);
        repeat (16) @(posedge clk);
        rstN <= 1'b1;
        repeat (4) @(posedge clk);

        testName = "scaling";
        configure(10, 0);
        repeat (4) randomDump(2047, 6);
        drain();
        configure(300, 5);
        repeat (4) randomDump(2047, 6);
        drain();
        configure(-1500, 9);
        repeat (4) randomDump(2047, 6);
        drain();

        testName = "saturation";
        configure(131071, 0);
        dumpBuf = '{131071, 131071};
        closeDump();
        dumpBuf = '{100000, 50000, 20000};
        closeDump();
        dumpBuf = '{-131072, 131071};
        closeDump();
        drain();
        configure(1, 0);
        dumpBuf = '{-131072, -1};
        closeDump();
        dumpBuf = '{-131072};
        closeDump();
        dumpBuf = '{131071};
        closeDump();
        drain();
        configure(1024, 4);
        dumpBuf = '{-2048};
        closeDump();
        drain();

        testName = "wideShift";
        configure(131071, 30);
        repeat (3) randomDump(131071, 6);
        drain();
        configure(-131072, 31);
        repeat (3) randomDump(131071, 6);
        drain();

        // two more grants only, so results pile up and the input buffer fills.
        testName = "backPressure";
        configure(77, 3);
        grantCap = grantsGiven + 2;
        repeat (16) randomDump(2047, 6);
        repeat (150) @(posedge clk);
        grantCap = openCap;
        drain();

        testName = "dumpBoundary";
        gapsOn = 1'b0;
        configure(-7, 2);
        repeat (8) randomDump(2047, 1);
        drain();
        gapsOn = 1'b1;

        finalCredits: assert (creditsReturned == samplesPushed)
            else begin
                errors++;
                $display("%0d input credits returned for %0d samples",
                         creditsReturned, samplesPushed);
            end
        $display("results checked %0d of %0d, errors %0d", resultsSeen, expCount, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: hdl/dumpScaleTop.sv
// ====================
// dumpScaleTop
// Dumped integrator with gain and output rescaling. Samples enter
// under upstream credits and results leave under downstream credits.
// ====================
`default_nettype none

module dumpScaleTop (
    input  wire logic                  clk,
    input  wire logic                  rstN,
    input  wire logic                  inValid,
    input  wire dumpScalePkg::sampleT  inSample,
    input  wire logic                  inLast,
    output logic                       inCredit,
    input  wire dumpScalePkg::sampleT  gain,
    input  wire dumpScalePkg::shiftT   shift,
    output logic                       outValid,
    output dumpScalePkg::resultT       outResult,
    input  wire logic                  outCredit
);

    logic                 sampleValid;
    dumpScalePkg::sampleT sample;
    logic                 sampleLast;
    logic                 sumValid;
    dumpScalePkg::accT    sum;
    logic                 scaledValid;
    dumpScalePkg::resultT scaled;
    logic                 resultCredit;

    sampleIngress sampleIngress_inst (
        .clk          (clk),
        .rstN         (rstN),
        .inValid      (inValid),
        .inSample     (inSample),
        .inLast       (inLast),
        .inCredit     (inCredit),
        .resultCredit (resultCredit),
        .sampleValid  (sampleValid),
        .sample       (sample),
        .sampleLast   (sampleLast)
    );

    dumpAccumulator dumpAccumulator_inst (
        .clk         (clk),
        .rstN        (rstN),
        .sampleValid (sampleValid),
        .sample      (sample),
        .sampleLast  (sampleLast),
        .gain        (gain),
        .sumValid    (sumValid),
        .sum         (sum)
    );

    accumScaler accumScaler_inst (
        .clk         (clk),
        .rstN        (rstN),
        .sumValid    (sumValid),
        .sum         (sum),
        .shift       (shift),
        .scaledValid (scaledValid),
        .scaled      (scaled)
    );

    resultEgress resultEgress_inst (
        .clk          (clk),
        .rstN         (rstN),
        .scaledValid  (scaledValid),
        .scaled       (scaled),
        .outCredit    (outCredit),
        .outValid     (outValid),
        .outResult    (outResult),
        .resultCredit (resultCredit)
    );

endmodule

`default_nettype wire

// File: hdl/resultEgress.sv
// ====================
// resultEgress
// Buffers scaled results and sends one per downstream credit. Every
// send frees a result slot and is reported back to ingress.
// ====================
`default_nettype none

`include "dumpScale_macros.svh"

module resultEgress (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic                 scaledValid,
    input  wire dumpScalePkg::resultT scaled,
    input  wire logic                 outCredit,
    output logic                      outValid,
    output dumpScalePkg::resultT      outResult,
    output logic                      resultCredit
);

    // wide enough for any grant backlog a sane sink will build up.
    localparam int creditW = 8;

    logic               fifoEmpty;
    logic               send;
    logic [creditW-1:0] dnCredits;

    creditFifo #(
        .payloadT (dumpScalePkg::resultT),
        .depth    (`RESULT_DEPTH)
    ) creditFifo_inst (
        .clk      (clk),
        .rstN     (rstN),
        .push     (scaledValid),
        .pushData (scaled),
        .pop      (send),
        .popData  (outResult),
        .empty    (fifoEmpty)
    );

    assign send         = !fifoEmpty && (dnCredits != '0);
    assign outValid     = send;
    assign resultCredit = send;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            dnCredits <= '0;
        end else begin
            case ({outCredit, send})
                2'b10:   dnCredits <= dnCredits + 1'b1;
                2'b01:   dnCredits <= dnCredits - 1'b1;
                default: dnCredits <= dnCredits;
            endcase
        end
    end

    // a grant while the counter is saturated and nothing is sent would be lost.
    grantNoWrap: assert property (@(posedge clk) disable iff (!rstN)
        (dnCredits == '1 && outCredit) |-> send)
        else $error("resultEgress: downstream credit counter overflow");

endmodule

`default_nettype wire

// File: hdl/accumScaler.sv
// ====================
// accumScaler
// Cuts the 48-bit dumped sum to an 18-bit field by an arithmetic
// right shift of up to 30 bits, clamping symmetrically on overflow.
// Three pipeline stages with a valid bit alongside.
// ====================
`default_nettype none

`include "dumpScale_macros.svh"

module accumScaler (
    input  wire logic                clk,
    input  wire logic                rstN,
    input  wire logic                sumValid,
    input  wire dumpScalePkg::accT   sum,
    input  wire dumpScalePkg::shiftT shift,
    output logic                     scaledValid,
    output dumpScalePkg::resultT     scaled
);

    localparam int maxShift = `ACC_W - `RESULT_W;
    localparam int grpCnt   = 7;
    localparam int grpLo    = `ACC_W - 4 * grpCnt;

    localparam dumpScalePkg::resultT satHi = `SAT_MAX;
    localparam dumpScalePkg::resultT satLo = -(`SAT_MAX);

    logic                 v1;
    logic                 v2;
    dumpScalePkg::accT    sum1;
    logic [grpCnt-1:0]    zeroGrp;
    logic [grpCnt-1:0]    onesGrp;
    int                   offset;
    int                   fieldTop;
    int                   nextBound;
    logic                 upperZero;
    logic                 upperOnes;
    dumpScalePkg::resultT dataBits;
    logic                 satPos;
    logic                 satNeg;

    // stage one. Delay the sum and flag each 4-bit group of the upper bits.
    always_ff @(posedge clk) begin
        sum1 <= sum;
        for (int g = 0; g < grpCnt; g++) begin
            zeroGrp[g] <= (sum[grpLo + 4 * g +: 4] == 4'h0);
            onesGrp[g] <= (sum[grpLo + 4 * g +: 4] == 4'hf);
        end
    end

    // the field's top bit and everything above it must all equal the sign.
    // Bits below the first whole group are checked one by one.
    always_comb begin
        offset    = (int'(shift) > maxShift) ? maxShift : int'(shift);
        fieldTop  = offset + `RESULT_W - 1;
        nextBound = (fieldTop <= grpLo) ? grpLo
                                        : grpLo + 4 * ((fieldTop - grpLo + 3) / 4);
        upperZero = 1'b1;
        upperOnes = 1'b1;
        for (int i = `RESULT_W - 1; i < `ACC_W; i++) begin
            if (i >= fieldTop && i < nextBound) begin
                upperZero = upperZero & !sum1[i];
                upperOnes = upperOnes & sum1[i];
            end
        end
        for (int g = 0; g < grpCnt; g++) begin
            if (grpLo + 4 * g >= nextBound) begin
                upperZero = upperZero & zeroGrp[g];
                upperOnes = upperOnes & onesGrp[g];
            end
        end
    end

    // stage two. Field extract and overflow decision.
    always_ff @(posedge clk) begin
        dataBits <= sum1[offset +: `RESULT_W];
        satPos   <= !sum1[`ACC_W-1] && !upperZero;
        satNeg   <= sum1[`ACC_W-1] && !upperOnes;
    end

    // stage three. The negative clamp is symmetric with the positive one.
    always_ff @(posedge clk) begin
        if (satPos) begin
            scaled <= satHi;
        end else if (satNeg) begin
            scaled <= satLo;
        end else begin
            scaled <= dataBits;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            v1          <= 1'b0;
            v2          <= 1'b0;
            scaledValid <= 1'b0;
        end else begin
            v1          <= sumValid;
            v2          <= v1;
            scaledValid <= v2;
        end
    end

endmodule

`default_nettype wire

// File: hdl/dumpAccumulator.sv
// ====================
// dumpAccumulator
// Multiplies each sample by the gain and integrates the products.
// A last-marked product closes the dump and restarts from zero.
// ====================
`default_nettype none

`include "dumpScale_macros.svh"

module dumpAccumulator (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic                 sampleValid,
    input  wire dumpScalePkg::sampleT sample,
    input  wire logic                 sampleLast,
    input  wire dumpScalePkg::sampleT gain,
    output logic                      sumValid,
    output dumpScalePkg::accT         sum
);

    logic signed [2*`SAMPLE_W-1:0] fullProd;
    logic                          prodValid;
    logic                          prodLast;
    dumpScalePkg::accT             product;
    dumpScalePkg::accT             acc;

    assign fullProd = sample * gain;

    // product stage.
    always_ff @(posedge clk) begin
        product  <= dumpScalePkg::accT'(fullProd);
        prodLast <= sampleLast;
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            prodValid <= 1'b0;
            sumValid  <= 1'b0;
            acc       <= '0;
        end else begin
            prodValid <= sampleValid;
            sumValid  <= prodValid && prodLast;
            if (prodValid) begin
                // the closing product goes out with the sum, so the next
                // dump can start accumulating on the very next cycle.
                acc <= prodLast ? '0 : acc + product;
            end
        end
    end

    // accumulation wraps modulo 2^48.
    always_ff @(posedge clk) begin
        if (prodValid && prodLast) begin
            sum <= acc + product;
        end
    end

endmodule

`default_nettype wire

// File: hdl/sampleIngress.sv
// ====================
// sampleIngress
// Buffers upstream samples and returns one credit per pop. A dump
// is only released while a result slot is reserved for it.
// ====================
`default_nettype none

`include "dumpScale_macros.svh"

module sampleIngress (
    input  wire logic                 clk,
    input  wire logic                 rstN,
    input  wire logic                 inValid,
    input  wire dumpScalePkg::sampleT inSample,
    input  wire logic                 inLast,
    output logic                      inCredit,
    input  wire logic                 resultCredit,
    output logic                      sampleValid,
    output dumpScalePkg::sampleT      sample,
    output logic                      sampleLast
);

    localparam int creditW = $clog2(`RESULT_DEPTH + 1);

    dumpScalePkg::sampleEntryT pushEntry;
    dumpScalePkg::sampleEntryT headEntry;
    logic                      fifoEmpty;
    logic                      popEn;
    logic                      popLast;
    logic [creditW-1:0]        resultCredits;

    assign pushEntry = '{sample: inSample, last: inLast};

    creditFifo #(
        .payloadT (dumpScalePkg::sampleEntryT),
        .depth    (`IN_DEPTH)
    ) creditFifo_inst (
        .clk      (clk),
        .rstN     (rstN),
        .push     (inValid),
        .pushData (pushEntry),
        .pop      (popEn),
        .popData  (headEntry),
        .empty    (fifoEmpty)
    );

    // only the sample that closes a dump waits for a result credit.
    assign popEn   = !fifoEmpty && (!headEntry.last || (resultCredits != '0));
    assign popLast = popEn && headEntry.last;

    assign sampleValid = popEn;
    assign sample      = headEntry.sample;
    assign sampleLast  = headEntry.last;
    assign inCredit    = popEn;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            resultCredits <= creditW'(`RESULT_DEPTH);
        end else begin
            case ({popLast, resultCredit})
                2'b10:   resultCredits <= resultCredits - 1'b1;
                2'b01:   resultCredits <= resultCredits + 1'b1;
                default: resultCredits <= resultCredits;
            endcase
        end
    end

    // egress must never hand back more credits than result slots exist.
    creditBound: assert property (@(posedge clk) disable iff (!rstN)
        resultCredits <= creditW'(`RESULT_DEPTH))
        else $error("sampleIngress: result credit count above buffer depth");

endmodule

`default_nettype wire

// File: hdl/creditFifo.sv
// ====================
// creditFifo
// Synchronous circular-buffer FIFO for any payload type. The writer
// is expected to hold credits, so it never pushes into a full buffer.
// ====================
`default_nettype none

module creditFifo #(
    parameter type payloadT = logic,
    parameter int depth = 4
) (
    input  wire logic    clk,
    input  wire logic    rstN,
    input  wire logic    push,
    input  wire payloadT pushData,
    input  wire logic    pop,
    output payloadT      popData,
    output logic         empty
);

    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    payloadT          mem [depth];
    logic [ptrW-1:0]  wrPtr;
    logic [ptrW-1:0]  rdPtr;
    logic [cntW-1:0]  count;
    logic             full;

    function automatic logic [ptrW-1:0] nextPtr(input logic [ptrW-1:0] ptr);
        if (ptr == ptrW'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= pushData;
        end
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (push) begin
                wrPtr <= nextPtr(wrPtr);
            end
            if (pop) begin
                rdPtr <= nextPtr(rdPtr);
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // the head is visible without a read cycle.
    assign popData = mem[rdPtr];
    assign empty   = (count == '0);
    assign full    = (count == cntW'(depth));

    // a push into a full buffer means the writer broke its credit count.
    pushNotFull: assert property (@(posedge clk) disable iff (!rstN) push |-> !full)
        else $error("creditFifo: push while full");

    popNotEmpty: assert property (@(posedge clk) disable iff (!rstN) pop |-> !empty)
        else $error("creditFifo: pop while empty");

endmodule

`default_nettype wire

// File: hdl/dumpScalePkg.sv
// ====================
// dumpScalePkg
// Payload and configuration types for the dumped integrator.
// ====================
`default_nettype none

`include "dumpScale_macros.svh"

package dumpScalePkg;

    // signed sample, also used for the gain word.
    typedef logic signed [`SAMPLE_W-1:0] sampleT;

    // input buffer entry, a sample with its end-of-dump marker.
    typedef struct packed {
        sampleT sample;
        logic   last;
    } sampleEntryT;

    typedef logic signed [`ACC_W-1:0] accT;

    typedef logic signed [`RESULT_W-1:0] resultT;

    typedef logic [4:0] shiftT;

endpackage

`default_nettype wire

// File: hdl/dumpScale_macros.svh
// ====================
// dumpScale widths and depths
// Shared sizes for the dumped integrator: sample, accumulator and
// result widths, buffer depths and the saturation limit.
// ====================
`ifndef DUMPSCALE_MACROS_SVH
`define DUMPSCALE_MACROS_SVH

`define SAMPLE_W 18
`define ACC_W 48
`define RESULT_W 18

// buffer depths double as the credit counts of the two loops.
`define IN_DEPTH 8
`define RESULT_DEPTH 4

`define SAT_MAX 131071

`endif
